// File: Makefile
TOP = aes256_device_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --assert --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: flist.f
verilog/aes_pkg.sv
verilog/aes_round_key_if.sv
verilog/aes_sbox.sv
verilog/aes_key_expand.sv
verilog/aes_key_store.sv
verilog/aes_cipher.sv
verilog/aes_cmd_ctrl.sv
verilog/aes256_device.sv
tests/aes256_device_chk.sv
tests/aes256_monitor.sv
tests/aes256_device_tb.sv

// File: tests/aes256_device_chk.sv
// AES-256 device protocol assertions
module aes256_device_chk (
    input logic                                             clk,
    input logic                                             resetn,
    input logic                                             in_ready,
    input logic                                             out_valid,
    input logic                                             out_ready,
    input aes_pkg::block_t                                  out_data,
    input logic [$clog2(aes_pkg::cmd_queue_depth+1)-1:0]    queue_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // one counter per rule
    int stable_failures = 0;
    int reset_failures = 0;
    int accept_failures = 0;
    int fail_count;

    assign fail_count = stable_failures + reset_failures + accept_failures;

    // held result stays put until taken
    a_held_stable: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else
    begin
        stable_failures++;
        $error("out_data or out_valid changed while the result was held");
    end

    a_reset_quiet: assert property (@(posedge clk) !resetn |-> !out_valid)
    else
    begin
        reset_failures++;
        $error("out_valid was high during reset");
    end

    // full queue takes nothing new
    a_full_blocks: assert property (@(posedge clk) disable iff (!resetn)
        !in_ready |=> queue_count <= $past(queue_count))
    else
    begin
        accept_failures++;
        $error("the queue took a command while in_ready was low");
    end

endmodule

// File: tests/aes256_device_tb.sv
// AES-256 device testbench
module aes256_device_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import aes_pkg::*;

    localparam int clock_half = 50;
    localparam int reset_cycles = 8;
    // longest single wait, in cycles
    localparam int step_timeout = 2000;
    localparam logic [15:0] lfsr_seed = 16'd22;

    logic   clk;
    logic   resetn;
    logic   in_valid;
    logic   in_ready;
    cmd_e   in_cmd;
    block_t in_data;
    logic   out_valid;
    logic   out_ready;
    block_t out_data;

    // run bookkeeping shared with the monitor
    logic finish_run;
    int   timeout_count;
    int   error_count;
    logic all_received;
    logic aborted;

    aes256_device uut (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_cmd    (in_cmd),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    aes256_monitor u_monitor (
        .clk           (clk),
        .resetn        (resetn),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .finish_run    (finish_run),
        .timeout_count (timeout_count),
        .assert_count  (uut.u_chk.fail_count),
        .error_count   (error_count),
        .all_received  (all_received)
    );

    // protocol checks inside the device top
    bind aes256_device aes256_device_chk u_chk (
        .clk         (clk),
        .resetn      (resetn),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .queue_count (u_ctrl.count)
    );

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #clock_half clk = ~clk;
    end

    // random back-pressure, one lfsr bit per cycle
    initial
    begin
        logic [15:0] lfsr;
        lfsr = lfsr_seed;
        out_ready = 1'b0;
        forever
        begin
            @(negedge clk);
            lfsr = lfsr_step(lfsr);
            out_ready = lfsr[0];
        end
    end

    // called on a falling edge, returns on a falling edge
    task automatic send_command(input cmd_e cmd, input block_t data);
        int waited;
        waited = 0;
        in_valid = 1'b1;
        in_cmd = cmd;
        in_data = data;
        // in_ready only moves on rising edges
        while (!in_ready && waited < step_timeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready)
        begin
            $display("in_ready stayed low for %0d cycles, command not accepted at %0t",
                     waited, $time);
            timeout_count++;
            aborted = 1'b1;
        end
        // accepted on the rising edge in between
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    initial
    begin
        int fd;
        int n;
        int waited;
        logic [8*128-1:0] line_buf;
        logic [7:0] tag;
        logic [8*6-1:0] half;
        block_t word_a;
        bit failed;

        resetn = 1'b0;
        in_valid = 1'b0;
        in_cmd = cmd_encrypt;
        in_data = '0;
        finish_run = 1'b0;
        timeout_count = 0;
        aborted = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        // idle outputs get checked by the monitor here
        @(negedge clk);

        fd = $fopen("tests/aes256_trace.txt", "r");
        if (fd == 0)
        begin
            $display("the trace file tests/aes256_trace.txt could not be opened");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd))
        begin
            line_buf = '0;
            tag = '0;
            n = $fgets(line_buf, fd);
            if (n > 0)
                n = $sscanf(line_buf, "%s", tag);
            if (n > 0 && tag == "K")
            begin
                n = $sscanf(line_buf, "%s %s %h", tag, half, word_a);
                if (half == 48'("first"))
                    send_command(cmd_key_first, word_a);
                else
                    send_command(cmd_key_second, word_a);
            end
            else if (n > 0 && tag == "E")
            begin
                // expected value is the monitor's business
                n = $sscanf(line_buf, "%s %h", tag, word_a);
                send_command(cmd_encrypt, word_a);
            end
        end
        if (fd != 0)
            $fclose(fd);

        // drain remaining results
        waited = 0;
        while (!aborted && !all_received && waited < step_timeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (!aborted && !all_received)
        begin
            $display("results stopped arriving, gave up after %0d cycles at %0t",
                     waited, $time);
            timeout_count++;
        end

        finish_run = 1'b1;
        // summary line comes out on the rising edge
        @(negedge clk);
        failed = (error_count != 0) || (timeout_count != 0) || !all_received || aborted
                 || (uut.u_chk.fail_count != 0);
        if (failed)
            $display("STATUS: FAIL");
        else
            $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: tests/aes256_monitor.sv
// AES-256 result monitor
module aes256_monitor (
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_ready,
    input  logic            out_valid,
    input  logic            out_ready,
    input  aes_pkg::block_t out_data,
    input  logic            finish_run,
    input  int              timeout_count,
    input  int              assert_count,
    output int              error_count,
    output logic            all_received
);
    timeunit 1ns;
    timeprecision 1ps;
    import aes_pkg::*;

    localparam int reset_timeout = 100;

    // expected ciphertexts in trace order
    block_t expected [$];
    int num_checked;

    initial
    begin
        int fd;
        int n;
        int waited;
        logic [8*128-1:0] line_buf;
        logic [7:0] tag;
        block_t plain;
        block_t cipher;
        bit reported;

        error_count = 0;
        num_checked = 0;
        all_received = 1'b0;
        reported = 1'b0;

        fd = $fopen("tests/aes256_trace.txt", "r");
        if (fd == 0)
        begin
            $display("the monitor could not open the trace file");
            error_count++;
        end
        while (fd != 0 && !$feof(fd))
        begin
            line_buf = '0;
            tag = '0;
            n = $fgets(line_buf, fd);
            if (n > 0)
                n = $sscanf(line_buf, "%s %h %h", tag, plain, cipher);
            // only encrypt lines carry a result
            if (n == 3 && tag == "E")
                expected.push_back(cipher);
        end
        if (fd != 0)
            $fclose(fd);

        // reset release seen on a rising edge
        waited = 0;
        while (resetn !== 1'b1 && waited < reset_timeout)
        begin
            @(posedge clk);
            waited++;
        end
        if (resetn !== 1'b1)
        begin
            $display("reset was never released");
            error_count++;
        end
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1)
        begin
            $display("CHECK FAILED at %0t: after reset out_valid %b in_ready %b, want 0 and 1",
                     $time, out_valid, in_ready);
            error_count++;
        end

        forever
        begin
            @(posedge clk);
            // handshake edge
            if (resetn && out_valid && out_ready)
            begin
                if (num_checked >= expected.size())
                begin
                    $display("an extra ciphertext %h came out at %0t", out_data, $time);
                    error_count++;
                end
                else
                begin
                    if (out_data !== expected[num_checked])
                    begin
                        $display("CHECK FAILED at %0t: ciphertext %0d is %h, expected %h",
                                 $time, num_checked, out_data, expected[num_checked]);
                        error_count++;
                    end
                    num_checked++;
                end
            end
            all_received = (num_checked >= expected.size());
            if (finish_run && !reported)
            begin
                reported = 1'b1;
                if (num_checked < expected.size())
                begin
                    $display("only %0d of %0d ciphertexts came out",
                             num_checked, expected.size());
                    error_count++;
                end
                $display("checked %0d of %0d, errors %0d, timeouts %0d, assertion failures %0d",
                         num_checked, expected.size(), error_count, timeout_count,
                         assert_count);
            end
        end
    end

endmodule

// File: tests/aes256_trace.txt
# K <first|second> <128-bit key half, hex>
# E <plaintext, hex> <expected ciphertext, hex>
K first 000102030405060708090a0b0c0d0e0f
K second 101112131415161718191a1b1c1d1e1f
E 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
K first 603deb1015ca71be2b73aef0857d7781
K second 1f352c073b6108d72d9810a30914dff4
E 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
E ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
E 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
E f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7
K first 000102030405060708090a0b0c0d0e0f
K second 101112131415161718191a1b1c1d1e1f
E 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089

// File: verilog/aes256_device.sv
// AES-256 encryption device
module aes256_device (
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_valid,
    output logic            in_ready,
    input  aes_pkg::cmd_e   in_cmd,
    input  aes_pkg::block_t in_data,
    output logic            out_valid,
    input  logic            out_ready,
    output aes_pkg::block_t out_data
);
    import aes_pkg::*;

    // controller to key schedule
    logic                       expand_start;
    logic [2*block_width-1:0]   expand_key;
    logic                       expand_busy;

    // controller to cipher
    logic   blk_valid;
    logic   blk_ready;
    block_t blk_data;

    // round key write and read paths
    aes_round_key_if rk_if ();

    aes_cmd_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_cmd       (in_cmd),
        .in_data      (in_data),
        .expand_start (expand_start),
        .expand_key   (expand_key),
        .expand_busy  (expand_busy),
        .blk_valid    (blk_valid),
        .blk_ready    (blk_ready),
        .blk_data     (blk_data)
    );

    aes_key_expand u_key_expand (
        .clk          (clk),
        .resetn       (resetn),
        .expand_start (expand_start),
        .expand_key   (expand_key),
        .expand_busy  (expand_busy),
        .rk           (rk_if.expander)
    );

    aes_key_store u_key_store (
        .clk    (clk),
        .resetn (resetn),
        .rk     (rk_if.store)
    );

    aes_cipher u_cipher (
        .clk       (clk),
        .resetn    (resetn),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .blk_data  (blk_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .rk        (rk_if.cipher)
    );

endmodule

// File: verilog/aes_cipher.sv
// AES-256 iterative encrypter
module aes_cipher (
    input  logic            clk,
    input  logic            resetn,
    input  logic            blk_valid,
    output logic            blk_ready,
    input  aes_pkg::block_t blk_data,
    output logic            out_valid,
    input  logic            out_ready,
    output aes_pkg::block_t out_data,
    aes_round_key_if.cipher rk
);
    import aes_pkg::*;

    cipher_state_e state;
    logic [key_addr_width-1:0] round;
    block_t state_blk;
    block_t round_blk;
    logic [15:0][7:0] sb;
    logic [15:0][7:0] sr;
    logic [15:0][7:0] mc;
    logic last_round;

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // byte 0 is the most significant, state is column major
    for (genvar i = 0; i < 16; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .in_byte  (state_blk[127-8*i -: 8]),
            .out_byte (sb[i])
        );
    end

    // row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                sr[r + 4*c] = sb[r + 4*((c + r) % 4)];
        end
    end

    // MixColumns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mc[4*c]     = xtime(sr[4*c]) ^ xtime(sr[4*c+1]) ^ sr[4*c+1]
                        ^ sr[4*c+2] ^ sr[4*c+3];
            mc[4*c+1]   = sr[4*c] ^ xtime(sr[4*c+1]) ^ xtime(sr[4*c+2])
                        ^ sr[4*c+2] ^ sr[4*c+3];
            mc[4*c+2]   = sr[4*c] ^ sr[4*c+1] ^ xtime(sr[4*c+2])
                        ^ xtime(sr[4*c+3]) ^ sr[4*c+3];
            mc[4*c+3]   = xtime(sr[4*c]) ^ sr[4*c] ^ sr[4*c+1]
                        ^ sr[4*c+2] ^ xtime(sr[4*c+3]);
        end
    end

    // final round skips MixColumns
    assign last_round = (round == key_addr_width'(num_rounds));

    always_comb
    begin
        for (int i = 0; i < 16; i++)
            round_blk[127-8*i -: 8] = last_round ? sr[i] : mc[i];
    end

    // round 0 while idle, so the accept edge adds key 0
    assign rk.rd_addr = round;
    assign blk_ready = (state == cs_idle);
    assign out_valid = (state == cs_done);
    assign out_data = state_blk;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= cs_idle;
            round <= '0;
        end
        else
        begin
            case (state)
                cs_idle:
                begin
                    if (blk_valid)
                    begin
                        state <= cs_round;
                        round <= 4'd1;
                    end
                end
                cs_round:
                begin
                    if (last_round)
                    begin
                        state <= cs_done;
                        round <= '0;
                    end
                    else
                        round <= round + 1'b1;
                end
                cs_done:
                begin
                    // result held until taken
                    if (out_ready)
                        state <= cs_idle;
                end
                default:
                    state <= cs_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == cs_idle && blk_valid)
            state_blk <= blk_data ^ rk.rd_data;
        else if (state == cs_round)
            state_blk <= round_blk ^ rk.rd_data;
    end

endmodule

// File: verilog/aes_cmd_ctrl.sv
// AES command queue and dispatch
module aes_cmd_ctrl (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  aes_pkg::cmd_e                       in_cmd,
    input  aes_pkg::block_t                     in_data,
    output logic                                expand_start,
    output logic [2*aes_pkg::block_width-1:0]   expand_key,
    input  logic                                expand_busy,
    output logic                                blk_valid,
    input  logic                                blk_ready,
    output aes_pkg::block_t                     blk_data
);
    import aes_pkg::*;

    cmd_e cmd_q [cmd_queue_depth];
    block_t data_q [cmd_queue_depth];
    logic [$clog2(cmd_queue_depth)-1:0] wr_ptr;
    logic [$clog2(cmd_queue_depth)-1:0] rd_ptr;
    logic [$clog2(cmd_queue_depth+1)-1:0] count;
    logic push;
    logic pop;
    logic not_empty;
    cmd_e head_cmd;
    block_t head_data;
    // first key half, held until the second arrives
    block_t key_hi;
    logic key_loaded;
    ctrl_state_e state;
    ctrl_state_e state_next;

    assign in_ready = (count != ($clog2(cmd_queue_depth+1))'(cmd_queue_depth));
    assign push = in_valid && in_ready;
    assign not_empty = (count != '0);
    assign head_cmd = cmd_q[rd_ptr];
    assign head_data = data_q[rd_ptr];

    assign expand_key = {key_hi, head_data};
    assign blk_valid = (state == st_encrypt);
    assign blk_data = head_data;

    always_comb
    begin
        pop = 1'b0;
        expand_start = 1'b0;
        state_next = state;
        case (state)
            st_idle:
            begin
                if (not_empty && head_cmd == cmd_key_first)
                    pop = 1'b1;
                // no rekey while a block may still read round keys
                else if (not_empty && head_cmd == cmd_key_second && blk_ready)
                begin
                    expand_start = 1'b1;
                    state_next = st_expand;
                end
                // encrypt waits for a first expanded key
                else if (not_empty && head_cmd == cmd_encrypt && key_loaded)
                    state_next = st_encrypt;
            end
            st_expand:
            begin
                if (!expand_busy)
                begin
                    pop = 1'b1;
                    state_next = st_idle;
                end
            end
            st_encrypt:
            begin
                if (blk_ready)
                begin
                    pop = 1'b1;
                    state_next = st_idle;
                end
            end
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= st_idle;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            key_loaded <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // power-of-two depth, pointers wrap on their own
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            if (state == st_expand && !expand_busy)
                key_loaded <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            cmd_q[wr_ptr] <= in_cmd;
            data_q[wr_ptr] <= in_data;
        end
        if (state == st_idle && not_empty && head_cmd == cmd_key_first)
            key_hi <= head_data;
    end

endmodule

// File: verilog/aes_key_expand.sv
// AES-256 key schedule
module aes_key_expand (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                expand_start,
    input  logic [2*aes_pkg::block_width-1:0]   expand_key,
    output logic                                expand_busy,
    aes_round_key_if.expander                   rk
);
    import aes_pkg::*;

    logic [key_addr_width-1:0] count;
    // two most recent round keys, prev1 is the newer
    block_t prev2;
    block_t prev1;
    block_t next_key;
    logic [word_width-1:0] last_word;
    logic [word_width-1:0] sub_in;
    logic [word_width-1:0] sub_out;
    logic [word_width-1:0] temp;
    logic [word_width-1:0] n0, n1, n2, n3;
    logic even_key;

    // even round keys take RotWord and rcon, odd ones SubWord only
    assign even_key = ~count[0];
    assign last_word = prev1[word_width-1:0];
    assign sub_in = even_key ? {last_word[23:0], last_word[31:24]} : last_word;

    // SubWord
    for (genvar i = 0; i < 4; i++)
    begin : g_sub
        aes_sbox u_sbox (
            .in_byte  (sub_in[8*i +: 8]),
            .out_byte (sub_out[8*i +: 8])
        );
    end

    // rcon index is the round-key pair number
    assign temp = even_key ? (sub_out ^ {rcon_table[count[3:1]], 24'h000000}) : sub_out;

    // each new word folds in the word eight back
    assign n0 = prev2[127:96] ^ temp;
    assign n1 = prev2[95:64] ^ n0;
    assign n2 = prev2[63:32] ^ n1;
    assign n3 = prev2[31:0] ^ n2;
    assign next_key = {n0, n1, n2, n3};

    // first two round keys are the cipher key halves
    assign rk.wr_en = expand_busy;
    assign rk.wr_addr = count;
    assign rk.wr_data = (count < 4'd2) ? (count[0] ? prev1 : prev2) : next_key;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            expand_busy <= 1'b0;
            count <= '0;
        end
        else if (expand_start)
        begin
            expand_busy <= 1'b1;
            count <= '0;
        end
        else if (expand_busy)
        begin
            count <= count + 1'b1;
            // last write at round key 14
            if (count == key_addr_width'(num_rounds))
                expand_busy <= 1'b0;
        end
    end

    // schedule window slides once the key halves are written
    always_ff @(posedge clk)
    begin
        if (expand_start)
        begin
            prev2 <= expand_key[2*block_width-1:block_width];
            prev1 <= expand_key[block_width-1:0];
        end
        else if (expand_busy && count >= 4'd2)
        begin
            prev2 <= prev1;
            prev1 <= next_key;
        end
    end

endmodule

// File: verilog/aes_key_store.sv
// AES round key store
module aes_key_store (
    input  logic            clk,
    input  logic            resetn,
    aes_round_key_if.store  rk
);
    import aes_pkg::*;

    // one entry per round key
    block_t keys [num_round_keys];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < num_round_keys; i++)
                keys[i] <= '0;
        end
        else if (rk.wr_en)
        begin
            keys[rk.wr_addr] <= rk.wr_data;
        end
    end

    // combinational read for the cipher
    assign rk.rd_data = keys[rk.rd_addr];

endmodule

// File: verilog/aes_pkg.sv
// AES-256 shared definitions
package aes_pkg;

    // data block and round key width
    localparam int block_width = 128;
    // key schedule word
    localparam int word_width = 32;

    // aes-256 round structure
    localparam int num_rounds = 14;
    localparam int num_round_keys = num_rounds + 1;
    localparam int key_addr_width = 4;

    // command queue entries
    localparam int cmd_queue_depth = 4;

    // round constants, indexed by round-key pair
    // entry 0 never used, pair numbering starts at 1
    localparam logic [7:0] rcon_table [8] = '{
        8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40
    };

    typedef logic [block_width-1:0] block_t;

    // command carried with each input word
    typedef enum logic [1:0] {
        cmd_encrypt    = 2'd0,
        cmd_key_first  = 2'd1,
        cmd_key_second = 2'd2
    } cmd_e;

    // dispatch fsm
    typedef enum logic [1:0] {
        st_idle,
        st_expand,
        st_encrypt
    } ctrl_state_e;

    // cipher fsm
    typedef enum logic [1:0] {
        cs_idle,
        cs_round,
        cs_done
    } cipher_state_e;

endpackage

// File: verilog/aes_round_key_if.sv
// AES round key port
interface aes_round_key_if;
    import aes_pkg::*;

    // write side, from the key schedule
    logic                       wr_en;
    logic [key_addr_width-1:0]  wr_addr;
    block_t                     wr_data;

    // read side, cipher addresses and store returns
    logic [key_addr_width-1:0]  rd_addr;
    block_t                     rd_data;

    modport expander (output wr_en, output wr_addr, output wr_data);

    modport cipher (output rd_addr, input rd_data);

    modport store (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

// File: verilog/aes_sbox.sv
// AES substitution box
module aes_sbox (
    input  logic [7:0] in_byte,
    output logic [7:0] out_byte
);

    logic [7:0] inv;

    // multiply in GF(2^8) mod x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // inverse as a^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] a3, a7, a15, a31, a63, a127;
        a3 = gf_mul(gf_mul(a, a), a);
        a7 = gf_mul(gf_mul(a3, a3), a);
        a15 = gf_mul(gf_mul(a7, a7), a);
        a31 = gf_mul(gf_mul(a15, a15), a);
        a63 = gf_mul(gf_mul(a31, a31), a);
        a127 = gf_mul(gf_mul(a63, a63), a);
        return gf_mul(a127, a127);
    endfunction

    assign inv = gf_inv(in_byte);

    // affine map, x ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
    assign out_byte = inv
                    ^ {inv[6:0], inv[7]}
                    ^ {inv[5:0], inv[7:6]}
                    ^ {inv[4:0], inv[7:5]}
                    ^ {inv[3:0], inv[7:4]}
                    ^ 8'h63;

endmodule
